/* bus_pkg.sv */
package bus_pkg;

    // single-cycle strobes, no handshake
    typedef struct packed {
        logic        read;
        logic        write;
        logic        addr;   // one bit selects between the two registers
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

    // register map
    localparam logic ADDR_STATUS = 1'b0;  // status word, read clears overrun
    localparam logic ADDR_DATA   = 1'b1;  // write queues tx byte, read pops rx entry

endpackage

/* uart_pkg.sv */
package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // one received frame as it sits in the rx queue
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;  // stop bit sampled low
    } rx_entry_t;

    // low bits of the status register, top bit first
    typedef struct packed {
        logic overrun;   // sticky, cleared by a status read
        logic rx_ready;  // rx queue holds data
        logic tx_ready;  // tx queue has room
    } uart_status_t;

endpackage

/* sync_fifo.sv */
module sync_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 8  // power of two, at least 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    payload_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;   // push into a full queue is dropped
    assign do_pop  = pop && !empty;

    assign full  = (count == (AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];       // head visible before the pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* uart_tx.sv */
module uart_tx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       fifo_empty,
    input  uart_byte_t fifo_data,
    output logic       fifo_pop,
    output logic       txd
);

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] BIT_END  = CW'(CLKS_PER_BIT - 1);
    // the idle cycle after this one completes the stop bit
    localparam logic [CW-1:0] STOP_END = CW'(CLKS_PER_BIT - 2);

    typedef enum logic [1:0] {IDLE, LOAD, SHIFT} tx_state_t;

    tx_state_t     state;
    logic [CW-1:0] baud_cnt;
    logic [3:0]    bit_cnt;   // 0 start, 1..8 data, 9 stop
    logic [8:0]    frame;     // stop bit above the data, shifted out lsb first

    assign fifo_pop = (state == IDLE) && !fifo_empty;

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            frame <= {1'b1, fifo_data};
        end else if (state == SHIFT && baud_cnt == BIT_END) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    txd <= 1'b1;
                    if (!fifo_empty) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    txd      <= 1'b0;  // start bit
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    state    <= SHIFT;
                end
                SHIFT: begin
                    if (bit_cnt == 4'd9 && baud_cnt == STOP_END) begin
                        state <= IDLE;
                    end else if (baud_cnt == BIT_END) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        txd      <= frame[0];
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* uart_rx.sv */
module uart_rx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      rxd,
    output logic      push,
    output rx_entry_t entry
);

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] BIT_END  = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_END = CW'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t     state;
    logic [CW-1:0] baud_cnt;
    logic [2:0]    bit_cnt;
    logic          rxd_meta;
    logic          rxd_sync;
    logic          rxd_last;
    logic          fall;
    uart_byte_t    shreg;

    assign fall = rxd_last && !rxd_sync;

    // entry goes into the queue at the middle of the stop bit
    assign push            = (state == STOP) && (baud_cnt == BIT_END);
    assign entry.data      = shreg;
    assign entry.frame_err = ~rxd_sync;

    // line idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA && baud_cnt == BIT_END) begin
            shreg <= {rxd_sync, shreg[7:1]};  // lsb arrives first
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    if (fall) begin
                        state <= START;
                    end
                end
                START: begin
                    if (baud_cnt == HALF_END) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rxd_sync ? IDLE : DATA;  // high here means a glitch
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (baud_cnt == BIT_END) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (baud_cnt == BIT_END) begin
                        state <= IDLE;  // a low stop needs a new falling edge
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* uart_regs.sv */
module uart_regs import bus_pkg::*; import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bus_req_t   bus_req,
    output bus_rsp_t   bus_rsp,
    input  logic       tx_full,
    output logic       tx_push,
    output uart_byte_t tx_data,
    input  logic       rx_empty,
    input  rx_entry_t  rx_head,
    output logic       rx_pop,
    input  logic       rx_push,   // receive push that found the queue full
    output logic       irq
);

    logic         rd_status;
    logic         rd_data;
    logic         wr_data;
    logic         overrun;
    uart_status_t status;

    assign rd_status = bus_req.read && (bus_req.addr == ADDR_STATUS);
    assign rd_data   = bus_req.read && (bus_req.addr == ADDR_DATA);
    assign wr_data   = bus_req.write && (bus_req.addr == ADDR_DATA);  // status writes ignored

    assign tx_push = wr_data && !tx_full;  // dropped when the queue is full
    assign tx_data = bus_req.wdata[7:0];
    assign rx_pop  = rd_data && !rx_empty;

    assign status.overrun  = overrun;
    assign status.rx_ready = ~rx_empty;
    assign status.tx_ready = ~tx_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_rsp.rdata <= '0;
        end else if (rd_status) begin
            bus_rsp.rdata <= {29'b0, status};
        end else if (rd_data) begin
            if (rx_empty) begin
                bus_rsp.rdata <= '0;
            end else begin
                bus_rsp.rdata <= {23'b0, rx_head.frame_err, rx_head.data};
            end
        end
    end

    // a loss in the same cycle as the clearing read stays visible
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            overrun <= 1'b0;
        end else if (rx_push) begin
            overrun <= 1'b1;
        end else if (rd_status) begin
            overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq <= 1'b0;
        end else begin
            irq <= ~rx_empty;
        end
    end

endmodule

/* uart_controller.sv */
module uart_controller import bus_pkg::*; import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  bus_req_t bus_req,
    output bus_rsp_t bus_rsp,
    input  logic     rxd,
    output logic     txd,
    output logic     irq
);

    logic       tx_push;
    logic       tx_pop;
    logic       tx_full;
    logic       tx_empty;
    uart_byte_t tx_wdata;
    uart_byte_t tx_head;

    logic       rx_push;
    logic       rx_pop;
    logic       rx_full;
    logic       rx_empty;
    logic       rx_drop;
    rx_entry_t  rx_entry;
    rx_entry_t  rx_head;

    assign rx_drop = rx_push && rx_full;  // only lost entries reach the overrun flag

    uart_regs u_uart_regs (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .tx_full  (tx_full),
        .tx_push  (tx_push),
        .tx_data  (tx_wdata),
        .rx_empty (rx_empty),
        .rx_head  (rx_head),
        .rx_pop   (rx_pop),
        .rx_push  (rx_drop),
        .irq      (irq)
    );

    sync_fifo #(
        .payload_t  (uart_byte_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .din   (tx_wdata),
        .pop   (tx_pop),
        .dout  (tx_head),
        .full  (tx_full),
        .empty (tx_empty)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_head),
        .fifo_pop   (tx_pop),
        .txd        (txd)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .clk   (clk),
        .rst   (rst),
        .rxd   (rxd),
        .push  (rx_push),
        .entry (rx_entry)
    );

    sync_fifo #(
        .payload_t  (rx_entry_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_push),
        .din   (rx_entry),
        .pop   (rx_pop),
        .dout  (rx_head),
        .full  (rx_full),
        .empty (rx_empty)
    );

endmodule

/* tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* uart_controller_properties.sv */
module uart_controller_properties import bus_pkg::*; (
    input logic     clk,
    input logic     rst,
    input bus_req_t bus_req,
    input bus_rsp_t bus_rsp,
    input logic     txd,
    input logic     irq
);
    timeunit 1ns;
    timeprecision 1ps;

    txd_idle_in_reset: assert property (@(posedge clk) rst |-> txd)
        else $error("txd low while reset is held");

    // no read strobe at the last edge, so read data must hold
    rdata_held: assert property (@(posedge clk) disable iff (rst)
        !$past(bus_req.read) |-> $stable(bus_rsp.rdata))
        else $error("rdata changed without a read strobe");

    irq_low_after_reset: assert property (@(posedge clk) $fell(rst) |=> !irq)
        else $error("irq high in the first cycle after reset");

endmodule

bind uart_controller uart_controller_properties u_properties (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .txd     (txd),
    .irq     (irq)
);

/* uart_controller_tb.sv */
module uart_controller_tb import bus_pkg::*; import uart_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BIT_CLKS   = 8;
    localparam int DEPTH      = 4;
    localparam int WAIT_LIMIT = 20 * BIT_CLKS;  // cycles, about two frames

    typedef struct packed {
        uart_byte_t data;
        logic       bad_stop;  // stop bit sent low
    } stim_t;

    stim_t stim [6] = '{
        '{8'h55, 1'b0},
        '{8'ha3, 1'b0},
        '{8'h00, 1'b1},
        '{8'hff, 1'b0},
        '{8'h81, 1'b1},
        '{8'h3c, 1'b0}
    };

    logic        clk;
    logic        rst;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    logic        rxd;
    logic        txd;
    logic        irq;
    logic [31:0] rdata;
    uart_byte_t  rand_byte;
    uart_byte_t  mon_byte;
    uart_byte_t  sent [$];
    uart_byte_t  seen [$];
    logic        writes_done;
    int          seed;
    int          n;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    uart_controller #(
        .CLKS_PER_BIT (BIT_CLKS),
        .FIFO_DEPTH   (DEPTH)
    ) u_uart_controller (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .rxd     (rxd),
        .txd     (txd),
        .irq     (irq)
    );

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    // bit 2 overrun, bit 1 rx_ready, bit 0 tx_ready
    function automatic logic [31:0] status_word(input logic ovr, input logic rx_rdy,
                                                input logic tx_rdy);
        return {29'b0, ovr, rx_rdy, tx_rdy};
    endfunction

    task automatic bus_write(input logic addr, input logic [31:0] data);
        bus_req.write = 1'b1;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        @(negedge clk);
        bus_req.write = 1'b0;
    endtask

    task automatic bus_read(input logic addr, output logic [31:0] data);
        bus_req.read = 1'b1;
        bus_req.addr = addr;
        @(negedge clk);
        bus_req.read = 1'b0;
        data = bus_rsp.rdata;  // registered on the edge after the strobe
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        while (irq !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timed_out(level ? "irq to rise" : "irq to fall");
            end
        end
    endtask

    task automatic send_frame(input uart_byte_t data, input logic bad_stop);
        int i;
        rxd = 1'b0;
        repeat (BIT_CLKS) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxd = data[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rxd = ~bad_stop;
        repeat (BIT_CLKS) @(negedge clk);
        rxd = 1'b1;
    endtask

    task automatic receive_frame(output uart_byte_t data);
        int cycles;
        int i;
        cycles = 0;
        while (txd !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                timed_out("a start bit on txd");
            end
        end
        repeat (BIT_CLKS / 2) @(negedge clk);  // middle of the start bit
        check("txd start bit", 32'(txd), 32'h0);
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            data[i] = txd;
        end
        repeat (BIT_CLKS) @(negedge clk);
        check("txd stop bit", 32'(txd), 32'h1);
    endtask

    initial begin
        bus_req     = '0;
        rxd         = 1'b1;
        writes_done = 1'b0;
        seed        = 32'he70f_6ccd;
        n           = 0;
        @(posedge clk);
        while (rst !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > 10) begin
                timed_out("reset to be released");
            end
        end
        @(negedge clk);

        check("irq", 32'(irq), 32'h0);
        bus_read(ADDR_STATUS, rdata);
        check("status", rdata, status_word(1'b0, 1'b0, 1'b1));
        bus_read(ADDR_DATA, rdata);
        check("rdata", rdata, 32'h0);

        foreach (stim[i]) begin
            bus_write(ADDR_DATA, {24'b0, stim[i].data});
            receive_frame(mon_byte);
            check("txd byte", 32'(mon_byte), 32'(stim[i].data));
            send_frame(stim[i].data, stim[i].bad_stop);
            wait_irq(1'b1);
            bus_read(ADDR_STATUS, rdata);
            check("status", rdata, status_word(1'b0, 1'b1, 1'b1));
            bus_read(ADDR_DATA, rdata);
            check("rdata", rdata, {23'b0, stim[i].bad_stop, stim[i].data});
            wait_irq(1'b0);
            bus_read(ADDR_STATUS, rdata);
            check("status", rdata, status_word(1'b0, 1'b0, 1'b1));
        end

        // fill the tx queue while the monitor collects frames
        fork
            begin
                bus_read(ADDR_STATUS, rdata);
                while (rdata[0]) begin
                    rand_byte = 8'($random(seed));
                    bus_write(ADDR_DATA, {24'b0, rand_byte});
                    sent.push_back(rand_byte);
                    if (sent.size() > 4 * DEPTH) begin
                        timed_out("tx_ready to drop");
                    end
                    bus_read(ADDR_STATUS, rdata);
                end
                writes_done = 1'b1;
            end
            begin
                while (!writes_done || seen.size() < sent.size()) begin
                    receive_frame(mon_byte);
                    seen.push_back(mon_byte);
                end
            end
        join
        repeat (20 * BIT_CLKS) begin
            @(negedge clk);
            check("txd idle", 32'(txd), 32'h1);
        end
        check("tx frame count", 32'(seen.size()), 32'(sent.size()));
        foreach (sent[i]) begin
            check("txd byte", 32'(seen[i]), 32'(sent[i]));
        end

        // one frame more than the rx queue holds
        sent.delete();
        for (n = 0; n <= DEPTH; n++) begin
            rand_byte = 8'($random(seed));
            sent.push_back(rand_byte);
            send_frame(rand_byte, 1'b0);
        end
        bus_read(ADDR_STATUS, rdata);
        check("status", rdata, status_word(1'b1, 1'b1, 1'b1));
        for (n = 0; n < DEPTH; n++) begin
            bus_read(ADDR_DATA, rdata);
            check("rdata", rdata, {24'b0, sent[n]});
        end
        bus_read(ADDR_STATUS, rdata);
        check("status", rdata, status_word(1'b0, 1'b0, 1'b1));
        wait_irq(1'b0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* files.f */
bus_pkg.sv
uart_pkg.sv
sync_fifo.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_controller.sv
tb_clock.sv
uart_controller_properties.sv
uart_controller_tb.sv

/* Makefile */
TOP = uart_controller_tb
BIN = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): files.f *.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f files.f --top-module $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
